//--- hacd_pkg.sv
// shared types for the accelerator core
// word, address and byte select types
// Wishbone classic request and response structs
// configuration map word offsets

`default_nettype none

package hacd_pkg;

   //////////////////////////////////////////////////
   // basic word types
   //////////////////////////////////////////////////

   // byte address on every bus
   typedef logic [31:0] addr_t;

   // data word
   typedef logic [31:0] data_t;

   // one bit per byte lane
   typedef logic [3:0]  sel_t;

   // word offset inside the configuration block
   typedef logic [2:0]  cfg_addr_t;

   //////////////////////////////////////////////////
   // Wishbone classic
   //////////////////////////////////////////////////

   // driven by a master, held until ack
   typedef struct packed {
      logic  cyc;
      logic  stb;
      logic  we;
      addr_t adr;
      data_t dat;
      sel_t  sel;
   } wb_req_t;

   // returned by a slave, dat valid with ack
   typedef struct packed {
      logic  ack;
      data_t dat;
   } wb_rsp_t;

   //////////////////////////////////////////////////
   // configuration map
   //////////////////////////////////////////////////

   localparam cfg_addr_t CFG_CTRL      = 3'd0;
   localparam cfg_addr_t CFG_BASE      = 3'd1;
   localparam cfg_addr_t CFG_COUNT     = 3'd2;
   localparam cfg_addr_t CFG_STATUS    = 3'd3;
   localparam cfg_addr_t CFG_STALL_CNT = 3'd4;

endpackage

`default_nettype wire

//--- hacd_cfg_regs.sv
// configuration slave on Wishbone
// BASE and COUNT registers, start pulse from CTRL
// sticky done bit, STATUS and STALL_CNT read back

`default_nettype none

module hacd_cfg_regs #(
   parameter int ENTRY_CNT_W = 8
) (
   input  logic                   clk_i,
   input  logic                   rst_n,
   input  hacd_pkg::wb_req_t      cfg_req,
   output hacd_pkg::wb_rsp_t      cfg_rsp,
   input  logic                   busy,
   input  logic                   done_pulse,
   input  hacd_pkg::data_t        stall_cnt,
   output logic                   start,
   output hacd_pkg::addr_t        base,
   output logic [ENTRY_CNT_W-1:0] count
);
   import hacd_pkg::*;

   cfg_addr_t offs;
   logic      acc;
   logic      wr;
   logic      ack_q;
   logic      done_q;
   data_t     rd_mux;
   data_t     rdata_q;

   // word offset from the byte address
   assign offs = cfg_req.adr[4:2];

   // one access per request, ack low again for a cycle after
   assign acc = cfg_req.cyc & cfg_req.stb & ~ack_q;
   assign wr  = acc & cfg_req.we;

   //////////////////////////////////////////////////
   // read decode
   //////////////////////////////////////////////////

   always_comb begin
      rd_mux = '0;
      case (offs)
         CFG_BASE:      rd_mux = base;
         CFG_COUNT:     rd_mux = data_t'(count);
         // done shows already in the cycle of the engine's pulse
         CFG_STATUS:    rd_mux = {30'd0, done_q | done_pulse, busy};
         CFG_STALL_CNT: rd_mux = stall_cnt;
         default:       rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (acc) begin
         rdata_q <= rd_mux;
      end
   end

   //////////////////////////////////////////////////
   // control registers
   //////////////////////////////////////////////////

   always_ff @(posedge clk_i or negedge rst_n) begin
      if (!rst_n) begin
         ack_q  <= 1'b0;
         start  <= 1'b0;
         done_q <= 1'b0;
         base   <= '0;
         count  <= '0;
      end else begin
         ack_q <= acc;
         // start pulse lands in the ack cycle
         start <= wr && (offs == CFG_CTRL) && cfg_req.dat[0];
         if (wr && (offs == CFG_BASE)) begin
            base <= {cfg_req.dat[31:2], 2'b00};
         end
         if (wr && (offs == CFG_COUNT)) begin
            count <= cfg_req.dat[ENTRY_CNT_W-1:0];
         end
         // a start that the engine accepts clears the old done
         if (start && !busy) begin
            done_q <= 1'b0;
         end else if (done_pulse) begin
            done_q <= 1'b1;
         end
      end
   end

   assign cfg_rsp = '{ack: ack_q, dat: rdata_q};

endmodule

`default_nettype wire

//--- hacd_list_init.sv
// free list builder
// FSM that writes entry i of the table with i plus 1
// last entry gets 0 as the end of list marker
// own Wishbone master, one write per entry

`default_nettype none

module hacd_list_init #(
   parameter int ENTRY_CNT_W = 8
) (
   input  logic                   clk_i,
   input  logic                   rst_n,
   input  logic                   start,
   input  hacd_pkg::addr_t        base,
   input  logic [ENTRY_CNT_W-1:0] count,
   output hacd_pkg::wb_req_t      eng_req,
   input  hacd_pkg::wb_rsp_t      eng_rsp,
   output logic                   busy,
   output logic                   done_pulse
);
   import hacd_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WRITE,
      ST_FINISH
   } state_e;

   state_e                 state;
   logic [ENTRY_CNT_W-1:0] idx;
   logic [ENTRY_CNT_W-1:0] last_q;
   addr_t                  base_q;
   logic                   last;
   logic                   launch;

   assign last   = (idx == last_q);
   // start only counts when no list is being written
   assign launch = start && (state != ST_WRITE);

   //////////////////////////////////////////////////
   // FSM
   //////////////////////////////////////////////////

   always_ff @(posedge clk_i or negedge rst_n) begin
      if (!rst_n) begin
         state <= ST_IDLE;
         idx   <= '0;
      end else begin
         case (state)
            ST_IDLE, ST_FINISH: begin
               if (launch) begin
                  idx   <= '0;
                  // empty table finishes at once
                  state <= (count == '0) ? ST_FINISH : ST_WRITE;
               end else begin
                  state <= ST_IDLE;
               end
            end
            ST_WRITE: begin
               if (eng_rsp.ack) begin
                  if (last) begin
                     state <= ST_FINISH;
                  end else begin
                     idx <= idx + 1'b1;
                  end
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // table geometry is latched so later config writes do not disturb a run
   always_ff @(posedge clk_i) begin
      if (launch) begin
         base_q <= base;
         last_q <= count - 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // bus request
   //////////////////////////////////////////////////

   always_comb begin
      eng_req = '0;
      if (state == ST_WRITE) begin
         eng_req.cyc = 1'b1;
         eng_req.stb = 1'b1;
         eng_req.we  = 1'b1;
         eng_req.sel = 4'hf;
         eng_req.adr = base_q + (addr_t'(idx) << 2);
         // next link, or end of list
         eng_req.dat = last ? '0 : data_t'(idx) + 32'd1;
      end
   end

   assign busy       = (state == ST_WRITE);
   assign done_pulse = (state == ST_FINISH);

endmodule

`default_nettype wire

//--- hacd_cpu_stall.sv
// CPU stall gate
// holds off new CPU cycles while the engine is busy
// counts clocks in which a CPU request waits

`default_nettype none

module hacd_cpu_stall (
   input  logic              clk_i,
   input  logic              rst_n,
   input  hacd_pkg::wb_req_t cpu_req,
   output hacd_pkg::wb_rsp_t cpu_rsp,
   output hacd_pkg::wb_req_t stall_req,
   input  hacd_pkg::wb_rsp_t stall_rsp,
   input  logic              busy,
   output hacd_pkg::data_t   stall_cnt
);

   logic req;
   logic pass;
   logic fwd_q;

   assign req  = cpu_req.cyc & cpu_req.stb;
   // a cycle already forwarded is never cut
   assign pass = req & (fwd_q | ~busy);

   always_comb begin
      stall_req     = cpu_req;
      stall_req.cyc = pass;
      stall_req.stb = pass;
      cpu_rsp       = stall_rsp;
      cpu_rsp.ack   = stall_rsp.ack & pass;
   end

   //////////////////////////////////////////////////
   // in-flight flag and stall counter
   //////////////////////////////////////////////////

   always_ff @(posedge clk_i or negedge rst_n) begin
      if (!rst_n) begin
         fwd_q     <= 1'b0;
         stall_cnt <= '0;
      end else begin
         // cleared by ack or by the CPU dropping its cycle
         fwd_q <= pass & ~stall_rsp.ack;
         if (req && !pass) begin
            stall_cnt <= stall_cnt + 32'd1;
         end
      end
   end

endmodule

`default_nettype wire

//--- hacd_mem_arb.sv
// memory port arbiter
// engine or CPU owns the port for one whole cycle
// engine preferred when both wait

`default_nettype none

module hacd_mem_arb (
   input  logic              clk_i,
   input  logic              rst_n,
   input  hacd_pkg::wb_req_t eng_req,
   output hacd_pkg::wb_rsp_t eng_rsp,
   input  hacd_pkg::wb_req_t stall_req,
   output hacd_pkg::wb_rsp_t stall_rsp,
   output hacd_pkg::wb_req_t mem_req,
   input  hacd_pkg::wb_rsp_t mem_rsp
);

   typedef enum logic [1:0] {
      OWN_NONE,
      OWN_ENG,
      OWN_CPU
   } owner_e;

   owner_e owner;
   logic   eng_want;
   logic   cpu_want;

   assign eng_want = eng_req.cyc & eng_req.stb;
   assign cpu_want = stall_req.cyc & stall_req.stb;

   //////////////////////////////////////////////////
   // owner select
   //////////////////////////////////////////////////

   always_ff @(posedge clk_i or negedge rst_n) begin
      if (!rst_n) begin
         owner <= OWN_NONE;
      end else begin
         case (owner)
            OWN_NONE: begin
               if (eng_want) begin
                  owner <= OWN_ENG;
               end else if (cpu_want) begin
                  owner <= OWN_CPU;
               end
            end
            // port is released on the owner's ack
            OWN_ENG, OWN_CPU: begin
               if (mem_rsp.ack) begin
                  owner <= OWN_NONE;
               end
            end
            default: owner <= OWN_NONE;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // routing
   //////////////////////////////////////////////////

   always_comb begin
      case (owner)
         OWN_ENG: mem_req = eng_req;
         OWN_CPU: mem_req = stall_req;
         default: mem_req = '0;
      endcase
   end

   // only the owner sees the ack
   assign eng_rsp   = '{ack: mem_rsp.ack & (owner == OWN_ENG), dat: mem_rsp.dat};
   assign stall_rsp = '{ack: mem_rsp.ack & (owner == OWN_CPU), dat: mem_rsp.dat};

endmodule

`default_nettype wire

//--- hacd_core.sv
// accelerator core top level
// config block and free list engine
// CPU stall gate and memory arbiter

`default_nettype none

module hacd_core #(
   parameter int ENTRY_CNT_W = 8
) (
   input  logic              clk_i,
   input  logic              rst_n,
   input  hacd_pkg::wb_req_t cpu_req,
   output hacd_pkg::wb_rsp_t cpu_rsp,
   input  hacd_pkg::wb_req_t cfg_req,
   output hacd_pkg::wb_rsp_t cfg_rsp,
   output hacd_pkg::wb_req_t mem_req,
   input  hacd_pkg::wb_rsp_t mem_rsp
);
   import hacd_pkg::*;

   // engine control
   logic                   start;
   addr_t                  base;
   logic [ENTRY_CNT_W-1:0] count;
   logic                   busy;
   logic                   done_pulse;
   data_t                  stall_cnt;

   // internal buses
   wb_req_t stall_req;
   wb_rsp_t stall_rsp;
   wb_req_t eng_req;
   wb_rsp_t eng_rsp;

   //////////////////////////////////////////////////
   // configuration and engine
   //////////////////////////////////////////////////

   hacd_cfg_regs #(
      .ENTRY_CNT_W (ENTRY_CNT_W)
   ) u_cfg_regs (
      .clk_i      (clk_i),
      .rst_n      (rst_n),
      .cfg_req    (cfg_req),
      .cfg_rsp    (cfg_rsp),
      .busy       (busy),
      .done_pulse (done_pulse),
      .stall_cnt  (stall_cnt),
      .start      (start),
      .base       (base),
      .count      (count)
   );

   hacd_list_init #(
      .ENTRY_CNT_W (ENTRY_CNT_W)
   ) u_list_init (
      .clk_i      (clk_i),
      .rst_n      (rst_n),
      .start      (start),
      .base       (base),
      .count      (count),
      .eng_req    (eng_req),
      .eng_rsp    (eng_rsp),
      .busy       (busy),
      .done_pulse (done_pulse)
   );

   //////////////////////////////////////////////////
   // CPU path to memory
   //////////////////////////////////////////////////

   hacd_cpu_stall u_cpu_stall (
      .clk_i     (clk_i),
      .rst_n     (rst_n),
      .cpu_req   (cpu_req),
      .cpu_rsp   (cpu_rsp),
      .stall_req (stall_req),
      .stall_rsp (stall_rsp),
      .busy      (busy),
      .stall_cnt (stall_cnt)
   );

   hacd_mem_arb u_mem_arb (
      .clk_i     (clk_i),
      .rst_n     (rst_n),
      .eng_req   (eng_req),
      .eng_rsp   (eng_rsp),
      .stall_req (stall_req),
      .stall_rsp (stall_rsp),
      .mem_req   (mem_req),
      .mem_rsp   (mem_rsp)
   );

endmodule

`default_nettype wire

//--- tb_hacd_core.sv
// testbench for the accelerator core
// clock, reset and a Wishbone memory model with a write log
// pattern file reader, compare tasks and a cycle timeout

`default_nettype none

module tb_hacd_core;
   timeunit 1ns;
   timeprecision 1ps;
   import hacd_pkg::*;

   logic    clk_i;
   logic    rst_n;
   wb_req_t cpu_req;
   wb_rsp_t cpu_rsp;
   wb_req_t cfg_req;
   wb_rsp_t cfg_rsp;
   wb_req_t mem_req;
   wb_rsp_t mem_rsp;

   data_t   mem [256];
   addr_t   wr_log [$];
   wb_req_t req_q;
   int      dly_left = -1;
   int      seed = 32'he33b;
   int      cycles = 0;
   int      cycle_limit = 0;
   int      n_checks = 0;
   int      n_errors = 0;

   hacd_core #(
      .ENTRY_CNT_W (8)
   ) uut (
      .clk_i   (clk_i),
      .rst_n   (rst_n),
      .cpu_req (cpu_req),
      .cpu_rsp (cpu_rsp),
      .cfg_req (cfg_req),
      .cfg_rsp (cfg_rsp),
      .mem_req (mem_req),
      .mem_rsp (mem_rsp)
   );

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycles++;
      if (cycle_limit > 0 && cycles > cycle_limit) begin
         $display("timeout after %0d cycles, a bus cycle never completed", cycles);
         $display("Something failed");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // memory model
   //////////////////////////////////////////////////

   // untouched words hold their own byte address
   function automatic data_t fill_word(input int idx);
      return 32'hc0de0000 + data_t'(idx << 2);
   endfunction

   // request seen at the rising edge, answered at the falling edge
   always @(posedge clk_i) begin
      req_q <= mem_req;
   end

   always @(negedge clk_i) begin
      if (mem_rsp.ack) begin
         mem_rsp.ack = 1'b0;
      end else if (rst_n && req_q.cyc && req_q.stb) begin
         if (dly_left < 0) begin
            dly_left = $unsigned($random(seed)) % 4;
         end
         if (dly_left == 0) begin
            if (req_q.we) begin
               mem[req_q.adr[9:2]] = req_q.dat;
               wr_log.push_back(req_q.adr);
            end
            mem_rsp.dat = mem[req_q.adr[9:2]];
            mem_rsp.ack = 1'b1;
         end
         dly_left--;
      end
   end

   //////////////////////////////////////////////////
   // compare and bus tasks
   //////////////////////////////////////////////////

   task automatic check_data(input string name, input data_t got, input data_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_addr(input string name, input addr_t got, input addr_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic cfg_access(input logic we, input cfg_addr_t offs, input data_t wdat,
                             output data_t rdat);
      @(negedge clk_i);
      cfg_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: addr_t'(offs) << 2, dat: wdat, sel: 4'hf};
      @(posedge clk_i);
      while (!cfg_rsp.ack) begin
         @(posedge clk_i);
      end
      rdat = cfg_rsp.dat;
      @(negedge clk_i);
      cfg_req = '0;
   endtask

   task automatic cpu_access(input logic we, input addr_t adr, input data_t wdat,
                             output data_t rdat);
      @(negedge clk_i);
      cpu_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat, sel: 4'hf};
      @(posedge clk_i);
      while (!cpu_rsp.ack) begin
         @(posedge clk_i);
      end
      rdat = cpu_rsp.dat;
      @(negedge clk_i);
      cpu_req = '0;
   endtask

   // entry i links to i plus 1, the last one ends the list
   task automatic check_table(input addr_t base, input int count);
      int idx;
      idx = int'(base[9:2]);
      for (int i = 0; i < count; i++) begin
         check_data($sformatf("mem[%h]", base + 4 * i), mem[idx + i],
                    (i == count - 1) ? 32'd0 : data_t'(i + 1));
      end
      // neighbours keep the fill pattern
      check_data("word below table", mem[idx - 1], fill_word(idx - 1));
      check_data("word above table", mem[idx + count], fill_word(idx + count));
   endtask

   //////////////////////////////////////////////////
   // pattern run
   //////////////////////////////////////////////////

   initial begin
      int    fd;
      int    mark;
      int    cur_count;
      string line;
      string op;
      string ops [$];
      data_t av [$];
      data_t bv [$];
      data_t a;
      data_t b;
      data_t rd;
      data_t last_stall;
      addr_t cur_base;
      cpu_req    = '0;
      cfg_req    = '0;
      mem_rsp    = '0;
      rst_n      = 1'b0;
      mark       = 0;
      cur_count  = 0;
      cur_base   = '0;
      last_stall = '0;
      for (int i = 0; i < 256; i++) begin
         mem[i] = fill_word(i);
      end
      fd = $fopen("hacd_core_patterns.txt", "r");
      if (fd == 0) begin
         n_errors++;
         $display("pattern file hacd_core_patterns.txt could not be opened");
      end else begin
         while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0 && line.substr(0, 0) != "#") begin
               if ($sscanf(line, "%s %h %h", op, a, b) == 3) begin
                  ops.push_back(op);
                  av.push_back(a);
                  bv.push_back(b);
               end
            end
         end
         $fclose(fd);
      end
      cycle_limit = ops.size() * 64;
      repeat (3) @(negedge clk_i);
      rst_n = 1'b1;
      foreach (ops[k]) begin
         case (ops[k])
            "cw": begin
               cfg_access(1'b1, cfg_addr_t'(av[k]), bv[k], rd);
               if (av[k] == CFG_BASE) begin
                  cur_base = {bv[k][31:2], 2'b00};
               end
               if (av[k] == CFG_COUNT) begin
                  cur_count = int'(bv[k][7:0]);
               end
            end
            "cr": begin
               cfg_access(1'b0, cfg_addr_t'(av[k]), '0, rd);
               check_data($sformatf("cfg_rsp.dat at offset %0d", av[k]), rd, bv[k]);
            end
            "pw": cpu_access(1'b1, av[k], bv[k], rd);
            "pr": begin
               cpu_access(1'b0, av[k], '0, rd);
               check_data("cpu_rsp.dat", rd, bv[k]);
            end
            "wd": begin
               rd = '0;
               if (k > 0 && ops[k - 1] == "cw" && av[k - 1] == CFG_CTRL
                   && cur_count != 0) begin
                  // a fresh run shows busy with the old done cleared
                  cfg_access(1'b0, CFG_STATUS, '0, rd);
                  check_data("status after start", rd, 32'h1);
               end
               while (!rd[1]) begin
                  cfg_access(1'b0, CFG_STATUS, '0, rd);
               end
               check_data("status", rd, 32'h2);
            end
            "tc": check_table(cur_base, cur_count);
            "mc": check_data($sformatf("mem[%h]", av[k]), mem[av[k][9:2]], bv[k]);
            "lm": mark = wr_log.size();
            "ln": check_data("write count", data_t'(wr_log.size() - mark), bv[k]);
            "sp": begin
               // CPU write held until the table is built
               cfg_access(1'b1, CFG_CTRL, 32'h1, rd);
               cpu_access(1'b1, av[k], bv[k], rd);
               check_addr("last write adr", wr_log[$], av[k]);
               check_addr("last table adr", wr_log[wr_log.size() - 2],
                          cur_base + addr_t'(4 * (cur_count - 1)));
            end
            "sc": begin
               cfg_access(1'b0, CFG_STALL_CNT, '0, rd);
               n_checks++;
               if (rd == 0 || rd < last_stall) begin
                  n_errors++;
                  $display("stall count %h is zero or fell below %h", rd, last_stall);
               end
               last_stall = rd;
            end
            default: begin
               n_errors++;
               $display("unknown operation %s in pattern line %0d", ops[k], k);
            end
         endcase
      end
      $display("checks %0d, errors %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- hacd_core.f
hacd_pkg.sv
hacd_cfg_regs.sv
hacd_list_init.sv
hacd_cpu_stall.sv
hacd_mem_arb.sv
hacd_core.sv
tb_hacd_core.sv

//--- hacd_core_patterns.txt
# columns: op a b, values in hex
# cw/cr: cfg offset, data or expected; pw/pr: cpu address, data or expected
# wd: wait done; tc: check table; mc: memory address, expected word
# lm: mark write log; ln: writes since mark; sp: start then cpu write; sc: stall count
cr 3 0
cr 4 0
cr 5 0
cr 7 0
cw 1 103
cw 2 8
cr 1 100
cr 2 8
pw 200 11223344
pw 204 a5a5f00d
pr 200 11223344
pr 204 a5a5f00d
lm 0 0
cw 0 1
wd 0 0
tc 0 0
mc 100 1
mc 11c 0
ln 0 8
cw 2 6
cw 1 180
sp 300 cafef00d
wd 0 0
tc 0 0
pr 300 cafef00d
sc 0 0
cw 2 0
lm 0 0
cw 0 1
wd 0 0
ln 0 0
cw 2 c
cw 1 240
lm 0 0
cw 0 1
cw 0 1
wd 0 0
tc 0 0
ln 0 c
sc 0 0
cr 3 2
